// File: Bender.yml
package:
  name: doppler_tracker

export_include_dirs:
  - .

sources:
  - doppler_cfg_pkg.sv
  - doppler_data_pkg.sv
  - doppler_settings.sv
  - ppx_gen.sv
  - zero_cross_counter.sv
  - rate_combiner.sv
  - doppler_tracker.sv
  - target: simulation
    files:
      - tb_doppler_tracker.sv

// File: doppler_cfg_pkg.sv
/*
  Doppler tracker configuration types
  Per-channel detector settings and period generator settings
*/

`default_nettype none

`include "doppler_consts.svh"

package doppler_cfg_pkg;

  // One channel of the zero crossing detector
  typedef struct packed {
    logic signed [`DOPPLER_SAMPLE_W-1:0] threshold;
    logic signed [`DOPPLER_SAMPLE_W-1:0] offset;
  } zc_cfg_t;

  typedef struct packed {
    zc_cfg_t i;
    zc_cfg_t q;
  } iq_zc_cfg_t;

  // Period length in clock cycles and pulse duty as a right shift
  typedef struct packed {
    logic [`DOPPLER_DATA_W-1:0] rate;
    logic [`DOPPLER_DUTY_W-1:0] duty_log2;
  } ppx_cfg_t;

endpackage

`default_nettype wire

// File: doppler_consts.svh
/*
  Doppler tracker constants
  Setting addresses, datapath widths and register reset values
*/

`ifndef DOPPLER_CONSTS_SVH
`define DOPPLER_CONSTS_SVH

// --------------------
// Settings bus map
`define DOPPLER_SR_THRESHOLD 8'd194
`define DOPPLER_SR_OFFSET    8'd195
`define DOPPLER_SR_PPX_RATE  8'd200
`define DOPPLER_SR_PPX_DUTY  8'd201

// --------------------
// Widths
`define DOPPLER_SAMPLE_W 16
`define DOPPLER_COUNT_W  32
`define DOPPLER_ADDR_W   8
`define DOPPLER_DATA_W   32
`define DOPPLER_DUTY_W   5

// Period of 1 s at a 200 MHz core clock
`define DOPPLER_PPX_RATE_RESET 32'd200000000
`define DOPPLER_PPX_DUTY_RESET 5'd2

`endif

// File: doppler_data_pkg.sv
/*
  Doppler tracker datapath types
  Baseband samples and crossing counts
*/

`default_nettype none

`include "doppler_consts.svh"

package doppler_data_pkg;

  typedef logic signed [`DOPPLER_SAMPLE_W-1:0] sample_t;

  // Complex baseband sample, I in the upper half
  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_sample_t;

  // Signed crossing count, also used for the combined rate
  typedef logic signed [`DOPPLER_COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// File: doppler_settings.sv
/*
  Doppler settings register bank
  Decodes bus writes into detector and period generator configuration
*/

`timescale 1ns/100ps
`default_nettype none

`include "doppler_consts.svh"

module doppler_settings (
  input  wire logic                         ce_clk,
  input  wire logic                         ce_rst,
  input  wire logic                         i_set_stb,
  input  wire logic [`DOPPLER_ADDR_W-1:0]   i_set_addr,
  input  wire logic [`DOPPLER_DATA_W-1:0]   i_set_data,
  output doppler_cfg_pkg::iq_zc_cfg_t       o_zc_cfg,
  output doppler_cfg_pkg::ppx_cfg_t         o_ppx_cfg
);

  logic [`DOPPLER_DATA_W-1:0] threshold_r;
  logic [`DOPPLER_DATA_W-1:0] offset_r;
  logic [`DOPPLER_DATA_W-1:0] ppx_rate_r;
  logic [`DOPPLER_DUTY_W-1:0] ppx_duty_r;

  // Addresses outside the map are ignored
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      threshold_r <= '0;
      offset_r    <= '0;
      ppx_rate_r  <= `DOPPLER_PPX_RATE_RESET;
      ppx_duty_r  <= `DOPPLER_PPX_DUTY_RESET;
    end else if (i_set_stb) begin
      case (i_set_addr)
        `DOPPLER_SR_THRESHOLD: threshold_r <= i_set_data;
        `DOPPLER_SR_OFFSET:    offset_r    <= i_set_data;
        `DOPPLER_SR_PPX_RATE:  ppx_rate_r  <= i_set_data;
        `DOPPLER_SR_PPX_DUTY:  ppx_duty_r  <= i_set_data[`DOPPLER_DUTY_W-1:0];
        default: ;
      endcase
    end
  end

  // Upper half of each word is I, lower half is Q
  assign o_zc_cfg.i.threshold = threshold_r[31:16];
  assign o_zc_cfg.q.threshold = threshold_r[15:0];
  assign o_zc_cfg.i.offset    = offset_r[31:16];
  assign o_zc_cfg.q.offset    = offset_r[15:0];

  assign o_ppx_cfg.rate      = ppx_rate_r;
  assign o_ppx_cfg.duty_log2 = ppx_duty_r;

endmodule

`default_nettype wire

// File: doppler_tracker.sv
/*
  Doppler tracker top level
  Settings, period generator, I and Q crossing counters and rate combiner
*/

`timescale 1ns/100ps
`default_nettype none

`include "doppler_consts.svh"

module doppler_tracker (
  input  wire logic                         ce_clk,
  input  wire logic                         ce_rst,
  input  wire logic                         i_set_stb,
  input  wire logic [`DOPPLER_ADDR_W-1:0]   i_set_addr,
  input  wire logic [`DOPPLER_DATA_W-1:0]   i_set_data,
  input  wire logic                         i_iq_valid,
  input  wire doppler_data_pkg::iq_sample_t i_iq,
  output doppler_data_pkg::count_t          o_rate,
  output logic                              o_rate_valid,
  output logic                              o_ppx
);

  doppler_cfg_pkg::iq_zc_cfg_t zc_cfg;
  doppler_cfg_pkg::ppx_cfg_t   ppx_cfg;
  logic                        tick;
  doppler_data_pkg::count_t    count_i;
  doppler_data_pkg::count_t    count_q;
  logic                        count_valid;

  doppler_settings u_settings (
    .ce_clk     (ce_clk),
    .ce_rst     (ce_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_zc_cfg   (zc_cfg),
    .o_ppx_cfg  (ppx_cfg)
  );

  ppx_gen u_ppx_gen (
    .ce_clk (ce_clk),
    .ce_rst (ce_rst),
    .i_cfg  (ppx_cfg),
    .o_tick (tick),
    .o_ppx  (o_ppx)
  );

  // --------------------
  // Each channel is signed by the other channel's sign bit
  zero_cross_counter #(.QUAD_CHANNEL(0)) u_zc_i (
    .ce_clk        (ce_clk),
    .ce_rst        (ce_rst),
    .i_cfg         (zc_cfg.i),
    .i_valid       (i_iq_valid),
    .i_sample      (i_iq.i),
    .i_other_neg   (i_iq.q[`DOPPLER_SAMPLE_W-1]),
    .i_tick        (tick),
    .o_count       (count_i),
    .o_count_valid (count_valid)
  );

  // Both counters latch together, only the I valid is used
  zero_cross_counter #(.QUAD_CHANNEL(1)) u_zc_q (
    .ce_clk        (ce_clk),
    .ce_rst        (ce_rst),
    .i_cfg         (zc_cfg.q),
    .i_valid       (i_iq_valid),
    .i_sample      (i_iq.q),
    .i_other_neg   (i_iq.i[`DOPPLER_SAMPLE_W-1]),
    .i_tick        (tick),
    .o_count       (count_q),
    .o_count_valid ()
  );

  rate_combiner u_rate_combiner (
    .ce_clk       (ce_clk),
    .ce_rst       (ce_rst),
    .i_count_i    (count_i),
    .i_count_q    (count_q),
    .i_valid      (count_valid),
    .o_rate       (o_rate),
    .o_rate_valid (o_rate_valid)
  );

endmodule

`default_nettype wire

// File: ppx_gen.sv
/*
  Period pulse generator
  Gives a one-cycle tick at the end of each period and a duty-shaped pulse
*/

`timescale 1ns/100ps
`default_nettype none

`include "doppler_consts.svh"

module ppx_gen (
  input  wire logic                      ce_clk,
  input  wire logic                      ce_rst,
  input  wire doppler_cfg_pkg::ppx_cfg_t i_cfg,
  output logic                           o_tick,
  output logic                           o_ppx
);

  logic [`DOPPLER_DATA_W-1:0] phase;
  logic [`DOPPLER_DUTY_W-1:0] duty_act;

  // Last cycle of the period
  assign o_tick = (phase >= i_cfg.rate - 1'b1);

  // --------------------
  // Phase counter
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      phase    <= '0;
      duty_act <= `DOPPLER_PPX_DUTY_RESET;
    end else if (o_tick) begin
      phase    <= '0;
      // New duty only applies from the next period
      duty_act <= i_cfg.duty_log2;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // High for the first rate >> duty cycles of the period
  assign o_ppx = (phase < (i_cfg.rate >> duty_act));

endmodule

`default_nettype wire

// File: rate_combiner.sv
/*
  Rate combiner
  Mean of the I and Q period counts as one signed rate
*/

`timescale 1ns/100ps
`default_nettype none

`include "doppler_consts.svh"

module rate_combiner (
  input  wire logic                     ce_clk,
  input  wire logic                     ce_rst,
  input  wire doppler_data_pkg::count_t i_count_i,
  input  wire doppler_data_pkg::count_t i_count_q,
  input  wire logic                     i_valid,
  output doppler_data_pkg::count_t      o_rate,
  output logic                          o_rate_valid
);

  localparam int CW = `DOPPLER_COUNT_W;

  logic signed [CW:0] iq_sum;

  // One bit of growth, then drop the LSB
  // Halving rounds toward minus infinity
  assign iq_sum = $signed({i_count_i[CW-1], i_count_i}) +
                  $signed({i_count_q[CW-1], i_count_q});

  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      o_rate       <= '0;
      o_rate_valid <= 1'b0;
    end else begin
      o_rate_valid <= i_valid;
      if (i_valid) begin
        o_rate <= iq_sum[CW:1];
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_doppler_tracker.sv
/*
  Doppler tracker testbench
  Random I/Q stimulus checked against a cycle model of the tracker
*/

`timescale 1ns/100ps
`default_nettype none

`include "doppler_consts.svh"

module tb_doppler_tracker;

  localparam int  SHAPE_RATE    = 64;
  localparam int  TRACK_RATE    = 256;
  localparam int  SHAPE_PERIODS = 24;
  localparam int  TRACK_PERIODS = 36;
  localparam int  MAX_CYCLES    = SHAPE_PERIODS * SHAPE_RATE + TRACK_PERIODS * TRACK_RATE + 1000;
  localparam real PI            = 3.14159265358979;
  localparam real AMP           = 16000.0;
  localparam int  NOISE         = 400;
  localparam int  SIGN_ANY  = 0;
  localparam int  SIGN_POS  = 1;
  localparam int  SIGN_NEG  = 2;
  localparam int  SIGN_ZERO = 3;

  logic                          ce_clk = 1'b0;
  logic                          ce_rst;
  logic                          i_set_stb;
  logic [`DOPPLER_ADDR_W-1:0]    i_set_addr;
  logic [`DOPPLER_DATA_W-1:0]    i_set_data;
  logic                          i_iq_valid;
  doppler_data_pkg::iq_sample_t  i_iq;
  doppler_data_pkg::count_t      o_rate;
  logic                          o_rate_valid;
  logic                          o_ppx;

  integer seed = 32'h1f0e8ecb;
  int     cycles = 0;
  int     rate_errors = 0;
  int     ppx_errors = 0;
  int     pulse_errors = 0;
  int     other_errors = 0;
  int     rates_seen = 0;
  int     nonzero_rates = 0;
  int     sign_from = 0;
  int     expect_sign = 0;
  int     stim_mode = 0;
  int     rot_dir = 1;
  int     off_i = 0;
  int     off_q = 0;
  int     nz_before;
  logic   stray_writes = 1'b0;
  real    angle = 0.0;

  // Model state
  logic [31:0]              m_thr, m_off, m_rate, m_phase;
  logic [4:0]               m_duty, m_duty_act;
  logic                     m_pos [2];
  doppler_data_pkg::count_t m_cnt [2];
  doppler_data_pkg::count_t m_cnt_out [2];
  logic                     m_cnt_valid, m_rate_valid;
  doppler_data_pkg::count_t m_rate_out;

  doppler_tracker i_doppler_tracker (
    .ce_clk       (ce_clk),
    .ce_rst       (ce_rst),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .i_iq_valid   (i_iq_valid),
    .i_iq         (i_iq),
    .o_rate       (o_rate),
    .o_rate_valid (o_rate_valid),
    .o_ppx        (o_ppx)
  );

  always #50 ce_clk = ~ce_clk;

  // Mean of two counts, rounded toward minus infinity
  function automatic doppler_data_pkg::count_t mean_of_counts(
    input doppler_data_pkg::count_t a, input doppler_data_pkg::count_t b);
    longint sum;
    sum = longint'(a) + longint'(b);
    return doppler_data_pkg::count_t'(sum >>> 1);
  endfunction

  // --------------------
  // Reference model
  always @(posedge ce_clk) begin : ref_model
    logic                     tick;
    logic                     oth_neg;
    int                       smp, thr, off, cen;
    doppler_data_pkg::count_t nxt;
    if (ce_rst) begin
      m_thr = '0;
      m_off = '0;
      m_rate = `DOPPLER_PPX_RATE_RESET;
      m_duty = `DOPPLER_PPX_DUTY_RESET;
      m_duty_act = `DOPPLER_PPX_DUTY_RESET;
      m_phase = '0;
      for (int ch = 0; ch < 2; ch++) begin
        m_pos[ch] = 1'b0;
        m_cnt[ch] = '0;
        m_cnt_out[ch] = '0;
      end
      m_cnt_valid = 1'b0;
      m_rate_valid = 1'b0;
      m_rate_out = '0;
    end else begin
      tick = (m_phase >= m_rate - 1);
      // Combiner works on last cycle's counts
      m_rate_valid = m_cnt_valid;
      if (m_cnt_valid) begin
        m_rate_out = mean_of_counts(m_cnt_out[0], m_cnt_out[1]);
      end
      for (int ch = 0; ch < 2; ch++) begin
        smp = (ch == 0) ? int'(i_iq.i) : int'(i_iq.q);
        oth_neg = (ch == 0) ? (i_iq.q < 0) : (i_iq.i < 0);
        thr = (ch == 0) ? int'($signed(m_thr[31:16])) : int'($signed(m_thr[15:0]));
        off = (ch == 0) ? int'($signed(m_off[31:16])) : int'($signed(m_off[15:0]));
        cen = smp - off;
        nxt = m_cnt[ch];
        if (i_iq_valid) begin
          if (!m_pos[ch] && cen > thr) begin
            m_pos[ch] = 1'b1;
            // I counts up when Q is negative, Q counts up when I is not
            if ((ch == 0 && oth_neg) || (ch == 1 && !oth_neg)) begin
              nxt = nxt + 1;
            end else begin
              nxt = nxt - 1;
            end
          end else if (m_pos[ch] && cen < -thr) begin
            m_pos[ch] = 1'b0;
          end
        end
        if (tick) begin
          m_cnt_out[ch] = nxt;
          m_cnt[ch] = '0;
        end else begin
          m_cnt[ch] = nxt;
        end
      end
      m_cnt_valid = tick;
      if (tick) begin
        m_phase = '0;
        m_duty_act = m_duty;
      end else begin
        m_phase = m_phase + 1;
      end
      if (i_set_stb) begin
        case (i_set_addr)
          `DOPPLER_SR_THRESHOLD: m_thr = i_set_data;
          `DOPPLER_SR_OFFSET:    m_off = i_set_data;
          `DOPPLER_SR_PPX_RATE:  m_rate = i_set_data;
          `DOPPLER_SR_PPX_DUTY:  m_duty = i_set_data[4:0];
          default: ;
        endcase
      end
    end
  end

  // --------------------
  // Compare tasks
  task automatic compare_rate(input doppler_data_pkg::count_t got,
                              input doppler_data_pkg::count_t exp);
    if (got !== exp) begin
      rate_errors++;
      $display("FAILED at %0t: o_rate got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic compare_ppx(input logic got, input logic exp);
    if (got !== exp) begin
      ppx_errors++;
      $display("FAILED at %0t: o_ppx got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_rate_pulse(input logic got, input logic exp);
    if (got !== exp) begin
      pulse_errors++;
      $display("FAILED at %0t: o_rate_valid got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic check_rate_sign(input doppler_data_pkg::count_t rate);
    if ((expect_sign == SIGN_POS && rate <= 0) || (expect_sign == SIGN_NEG && rate >= 0) ||
        (expect_sign == SIGN_ZERO && rate != 0)) begin
      other_errors++;
      $display("Rate %0d at %0t does not have the sign this test expects", rate, $time);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge ce_clk) begin
    if (!ce_rst) begin
      compare_ppx(o_ppx, m_phase < (m_rate >> m_duty_act));
      check_rate_pulse(o_rate_valid, m_rate_valid);
      if (o_rate_valid) begin
        if (m_rate_valid) begin
          compare_rate(o_rate, m_rate_out);
        end
        if (rates_seen >= sign_from) begin
          check_rate_sign(o_rate);
        end
        if (o_rate != 0) begin
          nonzero_rates++;
        end
        rates_seen++;
      end
    end
  end

  always @(posedge ce_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles before all tests finished", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  task automatic drive_cycle();
    int r;
    int step_deg;
    @(posedge ce_clk);
    #1;
    i_iq_valid = 1'b0;
    i_set_stb = 1'b0;
    if (stim_mode != 0 && ($random(seed) & 3) != 0) begin
      i_iq_valid = 1'b1;
      if (stim_mode == 1) begin
        step_deg = 10 + {$random(seed)} % 31;
        angle = angle + rot_dir * step_deg * PI / 180.0;
        i_iq.i = 16'($rtoi(AMP * $cos(angle)) + off_i);
        i_iq.q = 16'($rtoi(AMP * $sin(angle)) + off_q);
      end else begin
        i_iq.i = 16'($random(seed) % (NOISE + 1));
        i_iq.q = 16'($random(seed) % (NOISE + 1));
      end
    end
    if (stray_writes && ({$random(seed)} % 16) == 0) begin
      r = {$random(seed)} % 256;
      // Move off the four mapped addresses
      if (r == 194 || r == 195 || r == 200 || r == 201) begin
        r = r + 2;
      end
      i_set_stb = 1'b1;
      i_set_addr = 8'(r);
      i_set_data = $random(seed);
    end
  endtask

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(posedge ce_clk);
    #1;
    i_iq_valid = 1'b0;
    i_set_stb = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
  endtask

  task automatic run_periods(input int n);
    int target;
    target = rates_seen + n;
    while (rates_seen < target) begin
      drive_cycle();
    end
  endtask

  // First rate of a test may hold samples of the previous one
  task automatic start_test(input int sign);
    expect_sign = sign;
    sign_from = rates_seen + 1;
  endtask

  initial begin
    ce_rst = 1'b1;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_iq_valid = 1'b0;
    i_iq = '0;
    repeat (2) @(posedge ce_clk);
    #1;
    ce_rst = 1'b0;
    @(negedge ce_clk);
    compare_rate(o_rate, '0);

    // Pulse shape with random duty
    write_setting(`DOPPLER_SR_PPX_RATE, SHAPE_RATE);
    repeat (SHAPE_PERIODS / 3) begin
      write_setting(`DOPPLER_SR_PPX_DUTY, {$random(seed)} % 5);
      run_periods(3);
    end

    // Counterclockwise then clockwise rotation
    write_setting(`DOPPLER_SR_THRESHOLD, {16'd1000, 16'd1000});
    write_setting(`DOPPLER_SR_PPX_RATE, TRACK_RATE);
    stim_mode = 1;
    rot_dir = 1;
    start_test(SIGN_POS);
    run_periods(8);
    rot_dir = -1;
    start_test(SIGN_NEG);
    run_periods(8);

    // Noise inside the hysteresis band, then a threshold below it
    write_setting(`DOPPLER_SR_THRESHOLD, {16'd500, 16'd500});
    stim_mode = 2;
    start_test(SIGN_ZERO);
    run_periods(6);
    write_setting(`DOPPLER_SR_THRESHOLD, {16'd50, 16'd50});
    start_test(SIGN_ANY);
    nz_before = nonzero_rates;
    run_periods(6);
    if (nonzero_rates == nz_before) begin
      other_errors++;
      $display("No crossings were counted with the threshold below the noise");
    end

    // Shifted circle with stray writes to unmapped addresses
    off_i = $random(seed) % 2001;
    off_q = $random(seed) % 2001;
    write_setting(`DOPPLER_SR_OFFSET, {16'(off_i), 16'(off_q)});
    write_setting(`DOPPLER_SR_THRESHOLD, {16'd1000, 16'd1000});
    stim_mode = 1;
    rot_dir = 1;
    stray_writes = 1'b1;
    start_test(SIGN_POS);
    run_periods(8);

    $display("Errors: rate %0d, ppx %0d, rate pulse %0d, other %0d",
             rate_errors, ppx_errors, pulse_errors, other_errors);
    if (rate_errors + ppx_errors + pulse_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
doppler_cfg_pkg.sv
doppler_data_pkg.sv
doppler_settings.sv
ppx_gen.sv
zero_cross_counter.sv
rate_combiner.sv
doppler_tracker.sv
tb_doppler_tracker.sv

// File: zero_cross_counter.sv
/*
  Zero crossing counter for one channel
  Offset removal, hysteresis detector and signed crossing count per period
*/

`timescale 1ns/100ps
`default_nettype none

`include "doppler_consts.svh"

module zero_cross_counter #(
  parameter int QUAD_CHANNEL = 0
) (
  input  wire logic                      ce_clk,
  input  wire logic                      ce_rst,
  input  wire doppler_cfg_pkg::zc_cfg_t  i_cfg,
  input  wire logic                      i_valid,
  input  wire doppler_data_pkg::sample_t i_sample,
  input  wire logic                      i_other_neg,
  input  wire logic                      i_tick,
  output doppler_data_pkg::count_t       o_count,
  output logic                           o_count_valid
);

  localparam int W = `DOPPLER_SAMPLE_W;

  logic signed [W:0]         centered;
  logic signed [W:0]         thr_pos;
  logic signed [W:0]         thr_neg;
  logic                      pos_state;
  logic                      rise;
  logic                      count_up;
  doppler_data_pkg::count_t  step;
  doppler_data_pkg::count_t  count_r;
  doppler_data_pkg::count_t  count_next;

  // --------------------
  // Offset removal
  // One extra bit so the subtraction cannot wrap
  assign centered = $signed({i_sample[W-1], i_sample}) -
                    $signed({i_cfg.offset[W-1], i_cfg.offset});

  assign thr_pos = $signed({i_cfg.threshold[W-1], i_cfg.threshold});
  assign thr_neg = -thr_pos;

  // Negative to positive turn of the hysteresis state
  assign rise = i_valid && !pos_state && (centered > thr_pos);

  // --------------------
  // Hysteresis state
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      pos_state <= 1'b0;
    end else if (i_valid) begin
      if (!pos_state && (centered > thr_pos)) begin
        pos_state <= 1'b1;
      end else if (pos_state && (centered < thr_neg)) begin
        pos_state <= 1'b0;
      end
    end
  end

  // Sign from the other channel, Q uses the reverse rule
  // so counterclockwise rotation counts positive on both
  assign count_up = (QUAD_CHANNEL == 0) ? i_other_neg : !i_other_neg;
  assign step     = count_up ? 32'sd1 : -32'sd1;

  assign count_next = rise ? (count_r + step) : count_r;

  // --------------------
  // Period accumulation
  // A sample in the tick cycle still belongs to the ending period
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      count_r       <= '0;
      o_count       <= '0;
      o_count_valid <= 1'b0;
    end else begin
      o_count_valid <= i_tick;
      if (i_tick) begin
        o_count <= count_next;
        count_r <= '0;
      end else begin
        count_r <= count_next;
      end
    end
  end

endmodule

`default_nettype wire
